// File: Makefile
# Verilator build and run for the digitizer acquisition path

VERILATOR ?= verilator
TOP       ?= tb_scope_top
RTL_TOP   ?= scope_top
SEED      ?= 41285
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f $(FILELIST) \
		--top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR) -o V$(TOP)

# pass only when the testbench prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: adc/adc_calibrator.sv
module adc_calibrator import acq_pkg::*; (
    input  logic    sys_clock,
    input  logic    i_rst_n,
    input  logic    i_calib,
    input  sample_t i_sample,
    input  logic    i_sample_stb,
    output offset_t o_offset,
    output logic    o_calibrating
);

    logic [4:0]                     calib_cnt;  // strobes seen this run
    logic signed [ACC_WIDTH-1:0]    acc_ch1;
    logic signed [ACC_WIDTH-1:0]    acc_ch2;
    logic signed [SAMPLE_WIDTH-1:0] raw_ch1;
    logic signed [SAMPLE_WIDTH-1:0] raw_ch2;
    logic signed [ACC_WIDTH-1:0]    sum_ch1;
    logic signed [ACC_WIDTH-1:0]    sum_ch2;
    logic                           last_stb;

    // undo the correction applied by capture
    assign raw_ch1 = i_sample.ch1 + o_offset.ch1;
    assign raw_ch2 = i_sample.ch2 + o_offset.ch2;

    assign sum_ch1  = acc_ch1 + raw_ch1;
    assign sum_ch2  = acc_ch2 + raw_ch2;
    assign last_stb = i_sample_stb && (calib_cnt == 5'(CALIB_SAMPLES - 1));

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_calibrating <= 1'b0;
            o_offset      <= '0;
            calib_cnt     <= '0;
            acc_ch1       <= '0;
            acc_ch2       <= '0;
        end else if (!o_calibrating) begin
            if (i_calib) begin  // start a new run
                o_calibrating <= 1'b1;
                calib_cnt     <= '0;
                acc_ch1       <= '0;
                acc_ch2       <= '0;
            end
        end else if (last_stb) begin
            // offsets and the busy level change on the same edge
            o_offset.ch1  <= SAMPLE_WIDTH'(sum_ch1 >>> CALIB_SHIFT);
            o_offset.ch2  <= SAMPLE_WIDTH'(sum_ch2 >>> CALIB_SHIFT);
            o_calibrating <= 1'b0;
            calib_cnt     <= calib_cnt + 1'b1;
        end else if (i_sample_stb) begin
            acc_ch1   <= sum_ch1;
            acc_ch2   <= sum_ch2;
            calib_cnt <= calib_cnt + 1'b1;
        end
    end

    a_cnt_range : assert property (
        @(posedge sys_clock) disable iff (!i_rst_n)
        calib_cnt <= 5'(CALIB_SAMPLES)
    ) else $error("calibration counter past sample count");

endmodule

// File: adc/adc_capture.sv
module adc_capture import acq_pkg::*; (
    input  logic     sys_clock,
    input  logic     i_rst_n,
    input  adc_raw_t i_adc,
    input  logic     i_adc_dco,
    input  offset_t  i_offset,
    output sample_t  o_sample,
    output logic     o_sample_stb
);

    // invert msb, then sign extend to the sample width
    function automatic logic signed [SAMPLE_WIDTH-1:0] to_signed(
        input logic [RAW_WIDTH-1:0] raw
    );
        logic [RAW_WIDTH-1:0] flipped;
        flipped = {~raw[RAW_WIDTH-1], raw[RAW_WIDTH-2:0]};
        return SAMPLE_WIDTH'(signed'(flipped));
    endfunction

    function automatic logic at_rail(input logic [RAW_WIDTH-1:0] raw);
        return (&raw) || (~|raw);  // all ones or all zeros
    endfunction

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_sample     <= '0;
            o_sample_stb <= 1'b0;
        end else begin
            o_sample_stb <= i_adc_dco;
            if (i_adc_dco) begin
                o_sample.ch1  <= to_signed(i_adc.ch1) - i_offset.ch1;
                o_sample.ch2  <= to_signed(i_adc.ch2) - i_offset.ch2;
                o_sample.clip <= at_rail(i_adc.ch1) || at_rail(i_adc.ch2);
            end
        end
    end

    // the strobe from the converter is a single-cycle pulse
    a_stb_single : assert property (
        @(posedge sys_clock) disable iff (!i_rst_n)
        o_sample_stb |=> !o_sample_stb
    ) else $error("sample strobe held for two cycles");

endmodule

// File: common/acq_pkg.sv
package acq_pkg;

    // ********************
    // widths
    // ********************
    localparam int RAW_WIDTH    = 14;  // adc word
    localparam int SAMPLE_WIDTH = 16;  // corrected word
    localparam int ACC_WIDTH    = 18;  // 14 bits plus 4 bits growth

    // ********************
    // calibration
    // ********************
    localparam int CALIB_SAMPLES = 16;
    localparam int CALIB_SHIFT   = 4;  // log2 of CALIB_SAMPLES

    typedef struct packed {
        logic [RAW_WIDTH-1:0] ch1;  // offset binary
        logic [RAW_WIDTH-1:0] ch2;
    } adc_raw_t;

    typedef struct packed {
        logic signed [SAMPLE_WIDTH-1:0] ch1;
        logic signed [SAMPLE_WIDTH-1:0] ch2;
        logic                           clip;  // full scale on either channel
    } sample_t;

    typedef struct packed {
        logic signed [SAMPLE_WIDTH-1:0] ch1;
        logic signed [SAMPLE_WIDTH-1:0] ch2;
    } offset_t;

endpackage

// File: common/link_pkg.sv
package link_pkg;

    // ********************
    // serial line
    // ********************
    localparam int BIT_TICKS   = 8;  // sys_clock cycles per bit
    localparam int FRAME_BYTES = 3;  // tag, hi, lo

    localparam logic [7:0] TAG_CH1 = 8'hA1;
    localparam logic [7:0] TAG_CH2 = 8'hA2;

    // one sample word, seen as a number or as two bytes
    typedef union packed {
        logic signed [15:0] value;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } word_u;

    typedef struct packed {
        logic [7:0] data;
        logic       last;  // final byte of the frame
    } byte_port_t;

endpackage

// File: list.f
common/acq_pkg.sv
common/link_pkg.sv
adc/adc_capture.sv
adc/adc_calibrator.sv
uart/sample_framer.sv
uart/uart_arbiter.sv
uart/uart_tx.sv
logic/led_unit.sv
logic/scope_top.sv
tb/tb_scope_top.sv

// File: logic/led_unit.sv
module led_unit (
    input  logic sys_clock,
    input  logic i_rst_n,
    input  logic i_calibrating,
    input  logic i_clip,
    output logic o_led_r,
    output logic o_led_g,
    output logic o_led_b
);

    localparam int                  PWM_BITS   = 4;     // 16-cycle pwm period
    localparam int                  BLINK_BITS = 8;     // 256-cycle blink period
    localparam logic [PWM_BITS-1:0] GREEN_DUTY = 4'd2;  // dim idle glow

    logic [PWM_BITS-1:0]   pwm_cnt;
    logic [BLINK_BITS-1:0] blink_cnt;  // runs only while calibrating
    logic [BLINK_BITS-1:0] red_cnt;    // clip stretch

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pwm_cnt   <= '0;
            blink_cnt <= '0;
            red_cnt   <= '0;
            o_led_r   <= 1'b0;
            o_led_g   <= 1'b0;
            o_led_b   <= 1'b0;
        end else begin
            pwm_cnt   <= pwm_cnt + 1'b1;
            blink_cnt <= i_calibrating ? blink_cnt + 1'b1 : '0;
            if (i_clip) begin
                red_cnt <= '1;
            end else if (red_cnt != '0) begin
                red_cnt <= red_cnt - 1'b1;
            end
            // blue on for the first half of each blink period
            o_led_b <= i_calibrating && !blink_cnt[BLINK_BITS-1];
            o_led_g <= !i_calibrating && (pwm_cnt < GREEN_DUTY);
            o_led_r <= i_clip || (red_cnt != '0);
        end
    end

endmodule

// File: logic/scope_top.sv
module scope_top import acq_pkg::*, link_pkg::*; (
    input  logic     sys_clock,
    input  logic     i_rst_n,
    input  adc_raw_t i_adc,
    input  logic     i_adc_dco,
    input  logic     i_calib,
    output logic     o_tx,
    output logic     o_led_r,
    output logic     o_led_g,
    output logic     o_led_b
);

    sample_t    sample;
    logic       sample_stb;
    offset_t    offset;
    logic       calibrating;
    logic [1:0] req;       // bit 0 ch1, bit 1 ch2
    logic [1:0] taken;
    byte_port_t byte_ch1;
    byte_port_t byte_ch2;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;

    // ********************
    // acquisition
    // ********************
    adc_capture u_adc_capture (
        .sys_clock    (sys_clock),
        .i_rst_n      (i_rst_n),
        .i_adc        (i_adc),
        .i_adc_dco    (i_adc_dco),
        .i_offset     (offset),
        .o_sample     (sample),
        .o_sample_stb (sample_stb)
    );

    adc_calibrator u_adc_calibrator (
        .sys_clock     (sys_clock),
        .i_rst_n       (i_rst_n),
        .i_calib       (i_calib),
        .i_sample      (sample),
        .i_sample_stb  (sample_stb),
        .o_offset      (offset),
        .o_calibrating (calibrating)
    );

    // ********************
    // framing and uart
    // ********************
    sample_framer #(.TAG(TAG_CH1)) u_framer_ch1 (
        .sys_clock  (sys_clock),
        .i_rst_n    (i_rst_n),
        .i_word     (sample.ch1),
        .i_word_stb (sample_stb),
        .i_taken    (taken[0]),
        .o_req      (req[0]),
        .o_byte     (byte_ch1)
    );

    sample_framer #(.TAG(TAG_CH2)) u_framer_ch2 (
        .sys_clock  (sys_clock),
        .i_rst_n    (i_rst_n),
        .i_word     (sample.ch2),
        .i_word_stb (sample_stb),
        .i_taken    (taken[1]),
        .o_req      (req[1]),
        .o_byte     (byte_ch2)
    );

    uart_arbiter u_uart_arbiter (
        .sys_clock  (sys_clock),
        .i_rst_n    (i_rst_n),
        .i_req      (req),
        .i_byte_ch1 (byte_ch1),
        .i_byte_ch2 (byte_ch2),
        .i_busy     (tx_busy),
        .o_taken    (taken),
        .o_start    (tx_start),
        .o_data     (tx_data)
    );

    uart_tx u_uart_tx (
        .sys_clock (sys_clock),
        .i_rst_n   (i_rst_n),
        .i_start   (tx_start),
        .i_data    (tx_data),
        .o_tx      (o_tx),
        .o_busy    (tx_busy)
    );

    // ********************
    // status lights
    // ********************
    led_unit u_led_unit (
        .sys_clock     (sys_clock),
        .i_rst_n       (i_rst_n),
        .i_calibrating (calibrating),
        .i_clip        (sample.clip),
        .o_led_r       (o_led_r),
        .o_led_g       (o_led_g),
        .o_led_b       (o_led_b)
    );

endmodule

// File: tb/tb_scope_top.sv
module tb_scope_top import acq_pkg::*, link_pkg::*; #(
    parameter int unsigned SEED = 32'ha145
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_SCALE     = 1 << (RAW_WIDTH - 1);  // offset binary zero
    localparam int BLINK_CYCLES   = 256;
    localparam int LED_WAIT       = 20;     // cycles for a led to react
    localparam int TIMEOUT_CYCLES = 20000;  // about 60 frames of 240 cycles plus calibration

    logic     sys_clock;
    logic     i_rst_n;
    adc_raw_t i_adc;
    logic     i_adc_dco;
    logic     i_calib;
    logic     o_tx;
    logic     o_led_r;
    logic     o_led_g;
    logic     o_led_b;

    string              test_name;
    logic               check_on;      // compare frame payloads
    logic               calib_window;  // blue allowed
    logic               clip_phase;    // red allowed
    logic signed [15:0] model_off1;
    logic signed [15:0] model_off2;
    int                 frames_seen = 0;
    int                 cycle_cnt = 0;

    scope_top scope_top_inst (
        .sys_clock (sys_clock),
        .i_rst_n   (i_rst_n),
        .i_adc     (i_adc),
        .i_adc_dco (i_adc_dco),
        .i_calib   (i_calib),
        .o_tx      (o_tx),
        .o_led_r   (o_led_r),
        .o_led_g   (o_led_g),
        .o_led_b   (o_led_b)
    );

    always #50 sys_clock = ~sys_clock;

    // ********************
    // reporting
    // ********************
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] act);
        fail_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
    endtask

    always @(posedge sys_clock) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            fail_run("timeout, the run did not finish within the cycle limit");
        end
    end

    // ********************
    // reference model
    // ********************
    // offset binary to two's complement, minus the expected offset
    function automatic logic [15:0] expected_word(input logic [RAW_WIDTH-1:0] raw,
                                                  input logic signed [15:0] off);
        int value;
        value = int'(raw) - HALF_SCALE - int'(off);
        return 16'(value);
    endfunction

    task automatic check_frame(input logic [7:0] tag, input logic [15:0] word);
        logic [7:0]  exp_tag;
        logic [15:0] exp_word;
        exp_tag = frames_seen[0] ? TAG_CH2 : TAG_CH1;  // ch1 first, then alternate
        a_tag_order : assert (tag == exp_tag)
            else report_mismatch("fair_sharing", {8'h00, exp_tag}, {8'h00, tag});
        if (check_on) begin
            exp_word = (exp_tag == TAG_CH1) ? expected_word(i_adc.ch1, model_off1)
                                            : expected_word(i_adc.ch2, model_off2);
            a_payload : assert (word == exp_word)
                else report_mismatch(test_name, exp_word, word);
        end
        frames_seen++;
    endtask

    task automatic check_idle();
        a_idle : assert (o_tx && !o_led_r && !o_led_g && !o_led_b)
            else fail_run("line or LEDs not idle around reset");
    endtask

    // ********************
    // uart line decoder
    // ********************
    initial begin : uart_decoder
        logic [7:0] rx_byte;
        logic [7:0] frame_tag;
        logic [7:0] frame_hi;
        int         byte_pos;
        byte_pos = 0;
        forever begin
            @(negedge sys_clock);
            if (i_rst_n && !o_tx) begin
                repeat (BIT_TICKS / 2 - 1) @(negedge sys_clock);  // to mid start bit
                a_start_bit : assert (!o_tx) else fail_run("start bit ended early");
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_TICKS) @(negedge sys_clock);
                    rx_byte[i] = o_tx;  // lsb first
                end
                repeat (BIT_TICKS) @(negedge sys_clock);
                a_stop_bit : assert (o_tx) else report_mismatch("stop_bit", 16'h0001, 16'h0000);
                case (byte_pos)
                    0:       frame_tag = rx_byte;
                    1:       frame_hi  = rx_byte;
                    default: check_frame(frame_tag, {frame_hi, rx_byte});
                endcase
                byte_pos = (byte_pos + 1) % FRAME_BYTES;
            end
        end
    end

    // ********************
    // led assertions
    // ********************
    a_blue_calib : assert property (@(posedge sys_clock) disable iff (!i_rst_n)
        o_led_b |-> calib_window) else fail_run("blue LED lit outside calibration");
    a_green_calib : assert property (@(posedge sys_clock) disable iff (!i_rst_n)
        o_led_g |-> !o_led_b) else fail_run("green LED lit during calibration");
    a_red_clip : assert property (@(posedge sys_clock) disable iff (!i_rst_n)
        o_led_r |-> clip_phase) else fail_run("red LED lit without a clipped sample");

    // ********************
    // stimulus
    // ********************
    initial begin : adc_strobe
        forever begin
            repeat (3) @(posedge sys_clock);
            #1 i_adc_dco = 1'b1;  // one cycle in four
            @(posedge sys_clock);
            #1 i_adc_dco = 1'b0;
        end
    end

    task automatic wait_frames(input int n);
        int target;
        target = frames_seen + n;
        while (frames_seen < target) @(negedge sys_clock);
    endtask

    task automatic drive_raw(input logic [RAW_WIDTH-1:0] ch1, input logic [RAW_WIDTH-1:0] ch2);
        @(posedge sys_clock);
        #1;
        i_adc.ch1 = ch1;
        i_adc.ch2 = ch2;
    endtask

    task automatic random_raw(output logic [RAW_WIDTH-1:0] raw);
        raw = RAW_WIDTH'($urandom_range(15000, 1000));  // well away from the rails
    endtask

    initial begin : stimulus
        logic [RAW_WIDTH-1:0] x1;
        logic [RAW_WIDTH-1:0] x2;
        int                   d1;
        int                   d2;
        int                   cnt;
        void'($urandom(SEED));
        sys_clock    = 1'b0;
        i_rst_n      = 1'b0;
        i_adc_dco    = 1'b0;
        i_calib      = 1'b0;
        check_on     = 1'b0;
        calib_window = 1'b0;
        clip_phase   = 1'b0;
        model_off1   = '0;
        model_off2   = '0;
        random_raw(x1);
        random_raw(x2);
        i_adc.ch1 = x1;
        i_adc.ch2 = x2;

        test_name = "reset";
        repeat (10) begin
            @(negedge sys_clock);
            check_idle();
        end
        @(posedge sys_clock);
        #1 i_rst_n = 1'b1;
        @(negedge sys_clock);
        check_idle();

        test_name = "conversion";
        check_on  = 1'b1;
        wait_frames(6);

        // hold new values steady, then measure them as the offset
        test_name = "calibration";
        check_on  = 1'b0;
        random_raw(x1);
        random_raw(x2);
        drive_raw(x1, x2);
        repeat (8) @(posedge sys_clock);
        #1 calib_window = 1'b1;
        i_calib = 1'b1;
        @(posedge sys_clock);
        #1 i_calib = 1'b0;
        cnt = 0;
        while (!o_led_b && cnt < LED_WAIT) begin
            @(negedge sys_clock);
            cnt++;
        end
        a_blue_seen : assert (o_led_b) else fail_run("blue LED never lit during calibration");
        cnt = 0;
        while (cnt < BLINK_CYCLES) begin
            @(negedge sys_clock);
            cnt = o_led_b ? 0 : cnt + 1;
        end
        calib_window = 1'b0;
        model_off1   = 16'(int'(x1) - HALF_SCALE);
        model_off2   = 16'(int'(x2) - HALF_SCALE);
        wait_frames(4);  // flush frames latched before the new offsets
        check_on = 1'b1;
        wait_frames(6);

        test_name = "offset_step";
        check_on  = 1'b0;
        d1 = int'($urandom_range(1000)) - 500;
        d2 = int'($urandom_range(1000)) - 500;
        drive_raw(RAW_WIDTH'(int'(x1) + d1), RAW_WIDTH'(int'(x2) + d2));
        wait_frames(4);
        check_on = 1'b1;
        wait_frames(6);

        test_name  = "clip";
        check_on   = 1'b0;
        clip_phase = 1'b1;
        drive_raw('1, i_adc.ch2);  // full scale on ch1
        cnt = 0;
        while (!o_led_r && cnt < LED_WAIT) begin
            @(negedge sys_clock);
            cnt++;
        end
        a_red_seen : assert (o_led_r) else fail_run("red LED never lit after a clipped sample");
        wait_frames(4);
        check_on = 1'b1;
        wait_frames(4);

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: uart/sample_framer.sv
module sample_framer import acq_pkg::*, link_pkg::*; #(
    parameter logic [7:0] TAG = TAG_CH1
) (
    input  logic                           sys_clock,
    input  logic                           i_rst_n,
    input  logic signed [SAMPLE_WIDTH-1:0] i_word,
    input  logic                           i_word_stb,
    input  logic                           i_taken,
    output logic                           o_req,
    output byte_port_t                     o_byte
);

    word_u      held;      // latched sample
    logic [1:0] byte_idx;  // 0 tag, 1 hi, 2 lo

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_req    <= 1'b0;
            byte_idx <= '0;
        end else if (!o_req) begin
            if (i_word_stb) begin
                o_req    <= 1'b1;
                byte_idx <= '0;
            end
        end else if (i_taken) begin
            if (o_byte.last) begin
                o_req <= 1'b0;  // frame done
            end else begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    // samples arriving while a frame is pending are dropped
    always_ff @(posedge sys_clock) begin
        if (!o_req && i_word_stb) begin
            held.value <= i_word;
        end
    end

    always_comb begin
        case (byte_idx)
            2'd0:    o_byte.data = TAG;
            2'd1:    o_byte.data = held.bytes.hi;
            default: o_byte.data = held.bytes.lo;
        endcase
        o_byte.last = (byte_idx == 2'(FRAME_BYTES - 1));
    end

endmodule

// File: uart/uart_arbiter.sv
module uart_arbiter import link_pkg::*; (
    input  logic       sys_clock,
    input  logic       i_rst_n,
    input  logic [1:0] i_req,
    input  byte_port_t i_byte_ch1,
    input  byte_port_t i_byte_ch2,
    input  logic       i_busy,
    output logic [1:0] o_taken,
    output logic       o_start,
    output logic [7:0] o_data
);

    logic [1:0] grant;     // held for a whole frame
    logic       last_ch2;  // ch2 was served most recently
    byte_port_t cur_byte;

    assign cur_byte = grant[1] ? i_byte_ch2 : i_byte_ch1;
    assign o_start  = (|grant) && !i_busy;
    assign o_data   = cur_byte.data;
    assign o_taken  = o_start ? grant : 2'b00;

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            grant    <= '0;
            last_ch2 <= 1'b1;  // ch1 goes first
        end else if (grant == 2'b00) begin
            if (i_req[0] && (!i_req[1] || last_ch2)) begin
                grant    <= 2'b01;
                last_ch2 <= 1'b0;
            end else if (i_req[1]) begin
                grant    <= 2'b10;
                last_ch2 <= 1'b1;
            end
        end else if (o_start && cur_byte.last) begin
            grant <= '0;  // release after the final byte
        end
    end

    // the granted framer keeps requesting until its final byte is taken
    a_grant_onehot : assert property (
        @(posedge sys_clock) disable iff (!i_rst_n)
        $onehot0(grant) && ((grant & i_req) == grant)
    ) else $error("arbiter grant is two-hot or held without a request");

    // a byte goes out only to an idle transmitter, which then turns busy
    a_start_idle : assert property (
        @(posedge sys_clock) disable iff (!i_rst_n)
        o_start |-> !i_busy ##1 i_busy
    ) else $error("start issued to a busy transmitter");

endmodule

// File: uart/uart_tx.sv
module uart_tx import link_pkg::*; (
    input  logic       sys_clock,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic [7:0] i_data,
    output logic       o_tx,
    output logic       o_busy
);

    typedef logic [$clog2(BIT_TICKS)-1:0] tick_t;

    tick_t      tick_cnt;  // counts down within a bit
    logic [3:0] bit_cnt;   // 0 start, 1..8 data, 9 stop
    logic [8:0] shift_q;   // remaining data bits, then stop

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_tx     <= 1'b1;  // line idles high
            o_busy   <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!o_busy) begin
            if (i_start) begin
                o_tx     <= 1'b0;  // start bit
                o_busy   <= 1'b1;
                tick_cnt <= tick_t'(BIT_TICKS - 1);
                bit_cnt  <= '0;
            end
        end else if (tick_cnt != '0) begin
            tick_cnt <= tick_cnt - 1'b1;
        end else begin
            tick_cnt <= tick_t'(BIT_TICKS - 1);
            if (bit_cnt == 4'd9) begin
                o_busy <= 1'b0;  // end of stop bit
            end else begin
                o_tx    <= shift_q[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // lsb first, stop bit shifts in behind the data
    always_ff @(posedge sys_clock) begin
        if (!o_busy && i_start) begin
            shift_q <= {1'b1, i_data};
        end else if (o_busy && tick_cnt == '0) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    a_no_overrun : assert property (
        @(posedge sys_clock) disable iff (!i_rst_n)
        i_start |-> !o_busy
    ) else $error("transmitter started while busy");

endmodule
